//--- compile.f
+incdir+test
common/sib_pkg.sv
rtl/sib_poly_mem.sv
sample_in_ball/sample_in_ball_ctrl.sv
sample_in_ball/sample_in_ball_shuffler.sv
rtl/sample_in_ball_top.sv
test/sib_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := sib_tb
RTL_TOP    := sample_in_ball_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/sib_ref_model.svh
//############################
// SampleInBall reference model
//############################

`ifndef SIB_REF_MODEL_SVH
`define SIB_REF_MODEL_SVH

// Nonzero value for one sign bit
function automatic logic [SIB_COEFF_W-1:0] sign_coeff(input logic s);
  return s ? SIB_COEFF_W'(MLDSA_Q - 1) : SIB_COEFF_W'(1);
endfunction

// Two sign words, then bytes in stream order against i = 196 .. 255
function automatic void model_sample_in_ball(
  input  logic [31:0]            words [$],
  output logic [SIB_COEFF_W-1:0] poly [SIB_NUM_COEFF]
);
  logic [SIB_TAU-1:0] signs;
  logic [7:0]         j;
  int                 i;
  for (int k = 0; k < SIB_NUM_COEFF; k++) begin
    poly[k] = '0;
  end
  if (words.size() < 2) begin
    return;
  end
  // Second word only brings 28 sign bits
  signs = {words[1][27:0], words[0]};
  i = SIB_NUM_COEFF - SIB_TAU;
  for (int n = 2; n < words.size(); n++) begin
    for (int b = 0; b < SIB_NUM_SAMPLERS; b++) begin
      j = words[n][8*b +: 8];
      if (i < SIB_NUM_COEFF && int'(j) <= i) begin
        poly[i] = poly[j];
        poly[j] = sign_coeff(signs[0]);
        signs   = signs >> 1;
        i++;
      end
    end
  end
endfunction

`endif

//--- test/sib_tb.sv
//############################
// SampleInBall testbench
// Directed runs checked against the reference model
//############################

module sib_tb;
  import sib_pkg::*;

  localparam int          CLK_PERIOD     = 40;
  localparam logic [31:0] SEED           = 32'h7074_cc0c;
  // Six tests of at most about 2000 cycles each plus margin
  localparam int          TIMEOUT_CYCLES = 20000;

  logic                   clk;
  logic                   rst_b;
  logic                   zeroize_i;
  logic                   data_valid_i;
  logic [31:0]            data_i;
  logic                   data_hold_o;
  logic                   done_o;
  logic [7:0]             coeff_idx_i;
  logic [SIB_COEFF_W-1:0] coeff_o;

  int cycle_count = 0;
  int error_count;
  int test_count;
  int failed_tests;

  logic [31:0]            stream [$];
  logic [31:0]            fed_words [$];
  logic [7:0]             byte_q [$];
  logic [SIB_COEFF_W-1:0] exp_poly [SIB_NUM_COEFF];
  logic [SIB_COEFF_W-1:0] got_poly [SIB_NUM_COEFF];
  logic [SIB_COEFF_W-1:0] held_poly [SIB_NUM_COEFF];

  `include "sib_ref_model.svh"

  sample_in_ball_top uut (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .data_hold_o  (data_hold_o),
    .done_o       (done_o),
    .coeff_idx_i  (coeff_idx_i),
    .coeff_o      (coeff_o)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycle_count);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic report_coeff(input int k, input logic [SIB_COEFF_W-1:0] expected,
                              input logic [SIB_COEFF_W-1:0] actual);
    $display("[FAIL] t=%0t coeff_o[%0d] expected %0d got %0d", $time, k, expected, actual);
    error_count++;
  endtask

  task automatic zeroize_dut();
    data_valid_i = 1'b0;
    zeroize_i    = 1'b1;
    @(negedge clk);
    zeroize_i = 1'b0;
  endtask

  // Word stays on the bus until an edge sees valid high and hold low
  task automatic feed_word(input logic [31:0] w);
    logic taken;
    taken        = 1'b0;
    data_valid_i = 1'b1;
    data_i       = w;
    while (!taken) begin
      #(CLK_PERIOD / 4);
      taken = !data_hold_o;
      @(negedge clk);
    end
    fed_words.push_back(w);
  endtask

  // Host port is one cycle behind the index
  task automatic read_poly();
    coeff_idx_i = '0;
    for (int k = 0; k < SIB_NUM_COEFF; k++) begin
      @(negedge clk);
      got_poly[k] = coeff_o;
      coeff_idx_i = 8'(k + 1);
    end
  endtask

  task automatic check_poly();
    int nonzero;
    nonzero = 0;
    model_sample_in_ball(fed_words, exp_poly);
    for (int k = 0; k < SIB_NUM_COEFF; k++) begin
      if (got_poly[k] != exp_poly[k]) begin
        report_coeff(k, exp_poly[k], got_poly[k]);
      end
      if (got_poly[k] != '0) begin
        nonzero++;
        if (got_poly[k] != sign_coeff(1'b0) && got_poly[k] != sign_coeff(1'b1)) begin
          $display("[FAIL] t=%0t coeff_o[%0d] expected 1 or q-1 got %0d",
                   $time, k, got_poly[k]);
          error_count++;
        end
      end
    end
    if (nonzero != SIB_TAU) begin
      $display("[FAIL] t=%0t nonzero count expected %0d got %0d", $time, SIB_TAU, nonzero);
      error_count++;
    end
  endtask

  // Fresh run over the current stream until done_o is up
  task automatic run_stream();
    int n;
    n = 0;
    zeroize_dut();
    fed_words.delete();
    while (!done_o && n < stream.size()) begin
      feed_word(stream[n]);
      n++;
    end
    data_valid_i = 1'b0;
    if (!done_o) begin
      $display("Error at t=%0t: done_o never rose before the stream ran out", $time);
      error_count++;
    end
    repeat (2) @(negedge clk);
    read_poly();
    check_poly();
  endtask

  // Pad bytes are past the last sample and never examined
  task automatic pack_bytes();
    while (byte_q.size() % SIB_NUM_SAMPLERS != 0) begin
      byte_q.push_back(8'hff);
    end
    for (int k = 0; k < byte_q.size(); k += SIB_NUM_SAMPLERS) begin
      stream.push_back({byte_q[k+3], byte_q[k+2], byte_q[k+1], byte_q[k]});
    end
  endtask

  task automatic fill_random_stream(input int n);
    stream.delete();
    for (int k = 0; k < n; k++) begin
      stream.push_back($urandom());
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      $display("Test %0d %s: ok", test_count, name);
    end else begin
      failed_tests++;
      $display("Test %0d %s: %0d errors", test_count, name, error_count - errors_before);
    end
  endtask

  task automatic accept_all_test();
    int          errors_before;
    logic [59:0] signs;
    errors_before = error_count;
    stream.delete();
    stream.push_back(32'ha5c3_0f96);
    stream.push_back(32'h0abc_de12);
    signs = {stream[1][27:0], stream[0]};
    for (int k = 0; k < 17; k++) begin
      stream.push_back(32'h0);
    end
    run_stream();
    // j is always 0, so c[0] ends with the last sign and c[i] gets the one before
    if (got_poly[0] != sign_coeff(signs[59])) begin
      report_coeff(0, sign_coeff(signs[59]), got_poly[0]);
    end
    if (got_poly[196] != '0) begin
      report_coeff(196, '0, got_poly[196]);
    end
    for (int k = 0; k < 59; k++) begin
      if (got_poly[197+k] != sign_coeff(signs[k])) begin
        report_coeff(197 + k, sign_coeff(signs[k]), got_poly[197+k]);
      end
    end
    finish_test("accept-all stream", errors_before);
  endtask

  task automatic rejection_test();
    int errors_before;
    errors_before = error_count;
    stream.delete();
    byte_q.delete();
    stream.push_back(32'h3c69_e1b4);
    stream.push_back(32'h05d2_7a8f);
    for (int i = 196; i < 256; i++) begin
      // No byte can exceed the bound at 255
      if (i < 255) begin
        byte_q.push_back((i % 2 == 1) ? 8'hff : 8'(i + 1));
      end
      byte_q.push_back(8'((i * 37) % (i + 1)));
    end
    pack_bytes();
    run_stream();
    finish_test("rejection", errors_before);
  endtask

  task automatic sign_test();
    int          errors_before;
    logic [31:0] sign_lo [3];
    logic [31:0] sign_hi [3];
    errors_before = error_count;
    sign_lo = '{32'h0000_0000, 32'hffff_ffff, 32'h5a5a_5a5a};
    sign_hi = '{32'h0000_0000, 32'h0fff_ffff, 32'h0c3c_3c3c};
    for (int r = 0; r < 3; r++) begin
      stream.delete();
      byte_q.delete();
      stream.push_back(sign_lo[r]);
      stream.push_back(sign_hi[r]);
      for (int k = 0; k < SIB_TAU; k++) begin
        byte_q.push_back(8'((k * 13) % 196));
      end
      pack_bytes();
      run_stream();
    end
    finish_test("sign handling", errors_before);
  endtask

  task automatic done_idle_test();
    int errors_before;
    errors_before = error_count;
    stream.delete();
    byte_q.delete();
    stream.push_back(32'h1234_5678);
    stream.push_back(32'h0876_5432);
    for (int k = 0; k < SIB_TAU; k++) begin
      byte_q.push_back(8'((k * 29) % 190));
    end
    pack_bytes();
    zeroize_dut();
    fed_words.delete();
    // Every byte is accepted, so the 17th word carries samples 56 to 59
    for (int n = 0; n < 17; n++) begin
      if (done_o) begin
        $display("[FAIL] t=%0t done_o expected 0 got 1", $time);
        error_count++;
      end
      feed_word(stream[n]);
    end
    data_valid_i = 1'b0;
    if (!done_o) begin
      $display("[FAIL] t=%0t done_o expected 1 got 0", $time);
      error_count++;
    end
    repeat (2) @(negedge clk);
    read_poly();
    check_poly();
    held_poly = got_poly;
    for (int n = 0; n < 6; n++) begin
      feed_word($urandom());
    end
    data_valid_i = 1'b0;
    repeat (2) @(negedge clk);
    if (!done_o) begin
      $display("[FAIL] t=%0t done_o expected 1 got 0", $time);
      error_count++;
    end
    read_poly();
    for (int k = 0; k < SIB_NUM_COEFF; k++) begin
      if (got_poly[k] != held_poly[k]) begin
        report_coeff(k, held_poly[k], got_poly[k]);
      end
    end
    finish_test("done and idle", errors_before);
  endtask

  task automatic zeroize_test();
    int errors_before;
    errors_before = error_count;
    stream.delete();
    byte_q.delete();
    stream.push_back(32'h9e37_79b9);
    stream.push_back(32'h07f4_a7c1);
    for (int k = 0; k < 20; k++) begin
      byte_q.push_back(8'h10);
    end
    pack_bytes();
    zeroize_dut();
    fed_words.delete();
    foreach (stream[n]) begin
      feed_word(stream[n]);
    end
    // Last swap is still in its write cycle here
    zeroize_dut();
    read_poly();
    for (int k = 0; k < SIB_NUM_COEFF; k++) begin
      if (got_poly[k] != '0) begin
        report_coeff(k, '0, got_poly[k]);
      end
    end
    fill_random_stream(64);
    run_stream();
    // Zeroize from the done phase drops done_o again
    zeroize_dut();
    if (done_o) begin
      $display("[FAIL] t=%0t done_o expected 0 got 1", $time);
      error_count++;
    end
    finish_test("zeroize", errors_before);
  endtask

  task automatic random_test();
    int errors_before;
    errors_before = error_count;
    fill_random_stream(64);
    run_stream();
    finish_test("random stream", errors_before);
  endtask

  initial begin
    void'($urandom(SEED));
    clk          = 1'b0;
    rst_b        = 1'b0;
    zeroize_i    = 1'b0;
    data_valid_i = 1'b0;
    data_i       = '0;
    coeff_idx_i  = '0;
    error_count  = 0;
    test_count   = 0;
    failed_tests = 0;
    repeat (2) @(negedge clk);
    rst_b = 1'b1;
    if (data_hold_o) begin
      $display("[FAIL] t=%0t data_hold_o expected 0 got 1", $time);
      error_count++;
    end
    if (done_o) begin
      $display("[FAIL] t=%0t done_o expected 0 got 1", $time);
      error_count++;
    end
    accept_all_test();
    rejection_test();
    sign_test();
    done_idle_test();
    zeroize_test();
    random_test();
    $display("Summary: %0d tests, %0d failed, %0d check errors",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/sample_in_ball_top.sv
//############################
// SampleInBall top level
//############################

module sample_in_ball_top (
  input  logic                                                          clk,
  input  logic                                                          rst_b,
  input  logic                                                          zeroize_i,
  input  logic                                                          data_valid_i,
  input  logic [sib_pkg::SIB_NUM_SAMPLERS-1:0][sib_pkg::SIB_SAMPLE_W-1:0] data_i,
  output logic                                                          data_hold_o,
  output logic                                                          done_o,
  input  logic [$clog2(sib_pkg::SIB_NUM_COEFF)-1:0]                     coeff_idx_i,
  output logic [sib_pkg::SIB_COEFF_W-1:0]                               coeff_o
);
  import sib_pkg::*;

  // Controller to shuffler
  logic                    shuf_valid;
  logic                    shuf_hold;
  logic [SIB_SAMPLE_W-1:0] index_i;
  logic [SIB_SAMPLE_W-1:0] index_j;
  logic                    sign;

  // Shuffler to memory
  logic [1:0]                                            mem_cs;
  logic [1:0]                                            mem_we;
  logic [1:0][SIB_MEM_ADDR_W-1:0]                        mem_addr;
  logic [1:0][SIB_COEFFS_PER_WORD-1:0][SIB_COEFF_W-1:0]  mem_wrdata;
  logic [1:0][SIB_COEFFS_PER_WORD-1:0][SIB_COEFF_W-1:0]  mem_rddata;

  sample_in_ball_ctrl u_ctrl (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .data_valid_i (data_valid_i),
    .data_i       (data_i),
    .shuf_hold_i  (shuf_hold),
    .data_hold_o  (data_hold_o),
    .done_o       (done_o),
    .shuf_valid_o (shuf_valid),
    .index_i_o    (index_i),
    .index_j_o    (index_j),
    .sign_o       (sign)
  );

  sample_in_ball_shuffler u_shuffler (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (zeroize_i),
    .valid_i   (shuf_valid),
    .index_i_i (index_i),
    .index_j_i (index_j),
    .sign_i    (sign),
    .rddata_i  (mem_rddata),
    .hold_o    (shuf_hold),
    .cs_o      (mem_cs),
    .we_o      (mem_we),
    .addr_o    (mem_addr),
    .wrdata_o  (mem_wrdata)
  );

  sib_poly_mem u_mem (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .cs_i        (mem_cs),
    .we_i        (mem_we),
    .addr_i      (mem_addr),
    .wrdata_i    (mem_wrdata),
    .coeff_idx_i (coeff_idx_i),
    .rddata_o    (mem_rddata),
    .coeff_o     (coeff_o)
  );

endmodule

//--- sample_in_ball/sample_in_ball_shuffler.sv
//############################
// SampleInBall shuffler
// Two-cycle swap of coefficients i and j
//############################

module sample_in_ball_shuffler (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                zeroize_i,
  input  logic                                valid_i,
  input  logic [sib_pkg::SIB_SAMPLE_W-1:0]    index_i_i,
  input  logic [sib_pkg::SIB_SAMPLE_W-1:0]    index_j_i,
  input  logic                                sign_i,
  input  logic [1:0][sib_pkg::SIB_COEFFS_PER_WORD-1:0][sib_pkg::SIB_COEFF_W-1:0] rddata_i,
  output logic                                hold_o,
  output logic [1:0]                          cs_o,
  output logic [1:0]                          we_o,
  output logic [1:0][sib_pkg::SIB_MEM_ADDR_W-1:0] addr_o,
  output logic [1:0][sib_pkg::SIB_COEFFS_PER_WORD-1:0][sib_pkg::SIB_COEFF_W-1:0] wrdata_o
);
  import sib_pkg::*;

  sib_shuf_state_e shuf_ps;

  logic                                   accept;
  logic [SIB_SAMPLE_W-1:0]                idx_i_q;
  logic [SIB_SAMPLE_W-1:0]                idx_j_q;
  logic                                   sign_q;
  logic [SIB_MEM_ADDR_W-1:0]              word_i_q;
  logic [SIB_MEM_ADDR_W-1:0]              word_j_q;
  logic [$clog2(SIB_COEFFS_PER_WORD)-1:0] lane_i_q;
  logic [$clog2(SIB_COEFFS_PER_WORD)-1:0] lane_j_q;
  logic                                   same_word;
  logic [SIB_COEFF_W-1:0]                 old_j;
  logic [SIB_COEFF_W-1:0]                 sign_val;
  logic [SIB_COEFFS_PER_WORD-1:0][SIB_COEFF_W-1:0] wr_word_i;
  logic [SIB_COEFFS_PER_WORD-1:0][SIB_COEFF_W-1:0] wr_word_j;

  assign accept = (shuf_ps == SHUF_READ) & valid_i;
  assign hold_o = (shuf_ps == SHUF_WRITE);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      shuf_ps <= SHUF_READ;
    end else if (zeroize_i) begin
      shuf_ps <= SHUF_READ;
    end else if (accept) begin
      shuf_ps <= SHUF_WRITE;
    end else begin
      shuf_ps <= SHUF_READ;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      idx_i_q <= index_i_i;
      idx_j_q <= index_j_i;
      sign_q  <= sign_i;
    end
  end

  assign {word_i_q, lane_i_q} = idx_i_q;
  assign {word_j_q, lane_j_q} = idx_j_q;
  assign same_word = (word_i_q == word_j_q);

  // Old c[j] comes from the port 1 read
  assign old_j    = rddata_i[1][lane_j_q];
  assign sign_val = sign_q ? SIB_COEFF_W'(MLDSA_Q - 1) : SIB_COEFF_W'(1);

  // j lane goes last so i == j ends up holding the sign value
  always_comb begin
    wr_word_i = rddata_i[0];
    wr_word_j = rddata_i[1];
    wr_word_i[lane_i_q] = old_j;
    if (same_word) begin
      wr_word_j[lane_i_q] = old_j;
    end
    wr_word_j[lane_j_q] = sign_val;
  end

  assign wrdata_o[0] = wr_word_i;
  assign wrdata_o[1] = wr_word_j;

  always_comb begin
    if (hold_o) begin
      // Shared word is written once on port 1
      cs_o      = same_word ? 2'b10 : 2'b11;
      we_o      = cs_o;
      addr_o[0] = word_i_q;
      addr_o[1] = word_j_q;
    end else begin
      cs_o      = {2{valid_i}};
      we_o      = 2'b00;
      addr_o[0] = index_i_i[SIB_SAMPLE_W-1 -: SIB_MEM_ADDR_W];
      addr_o[1] = index_j_i[SIB_SAMPLE_W-1 -: SIB_MEM_ADDR_W];
    end
  end

  // Fisher-Yates never swaps with a j above i
  a_j_not_above_i: assert property (@(posedge clk) disable iff (!rst_b)
    hold_o |-> (idx_j_q <= idx_i_q));

endmodule

//--- sample_in_ball/sample_in_ball_ctrl.sv
//############################
// SampleInBall controller
// Sign buffering, rejection sampling, phase FSM
//############################

module sample_in_ball_ctrl (
  input  logic                                                          clk,
  input  logic                                                          rst_b,
  input  logic                                                          zeroize_i,
  input  logic                                                          data_valid_i,
  input  logic [sib_pkg::SIB_NUM_SAMPLERS-1:0][sib_pkg::SIB_SAMPLE_W-1:0] data_i,
  input  logic                                                          shuf_hold_i,
  output logic                                                          data_hold_o,
  output logic                                                          done_o,
  output logic                                                          shuf_valid_o,
  output logic [sib_pkg::SIB_SAMPLE_W-1:0]                              index_i_o,
  output logic [sib_pkg::SIB_SAMPLE_W-1:0]                              index_j_o,
  output logic                                                          sign_o
);
  import sib_pkg::*;

  sib_fsm_state_e fsm_ps;
  sib_fsm_state_e fsm_ns;

  logic [SIB_NUM_SAMPLERS*SIB_SAMPLE_W-1:0] data_word;
  logic [SIB_TAU-1:0]                  sign_buffer;
  logic [SIB_SAMPLE_W-1:0]             rej_value;
  logic [SIB_NUM_SAMPLERS-1:0]         sample_mask;
  logic [SIB_NUM_SAMPLERS-1:0]         sample_mask_d;
  logic [SIB_NUM_SAMPLERS-1:0]         sample_ok;
  logic                                index_found;
  logic [$clog2(SIB_NUM_SAMPLERS)-1:0] valid_index;
  logic                                active;
  logic                                scan_hold;
  logic                                accept;
  logic                                last_sample;

  assign data_word = data_i;

  // One rejection compare per unmasked byte
  always_comb begin
    for (int k = 0; k < SIB_NUM_SAMPLERS; k++) begin
      sample_ok[k] = sample_mask[k] & (data_i[k] <= rej_value);
    end
  end

  // First acceptable byte; everything up to it counts as examined
  always_comb begin
    index_found   = 1'b0;
    valid_index   = '0;
    sample_mask_d = sample_mask;
    for (int k = 0; k < SIB_NUM_SAMPLERS; k++) begin
      if (!index_found && sample_mask[k]) begin
        sample_mask_d[k] = 1'b0;
        if (sample_ok[k]) begin
          index_found = 1'b1;
          valid_index = k[$clog2(SIB_NUM_SAMPLERS)-1:0];
        end
      end
    end
  end

  assign active       = (fsm_ps == SIB_ACTIVE) & data_valid_i;
  assign shuf_valid_o = active & index_found;
  assign accept       = shuf_valid_o & ~shuf_hold_i;

  // Bytes after the selected one still need a look
  assign scan_hold   = index_found & (valid_index != '1);
  assign data_hold_o = active & (shuf_hold_i | scan_hold);

  assign last_sample = accept & (&rej_value);
  assign done_o      = (fsm_ps == SIB_DONE);

  assign index_i_o = rej_value;
  assign index_j_o = data_i[valid_index];
  assign sign_o    = sign_buffer[0];

  always_comb begin
    fsm_ns = fsm_ps;
    unique case (fsm_ps)
      SIB_IDLE: begin
        if (data_valid_i) fsm_ns = SIB_SIGN_BUFFER;
      end
      SIB_SIGN_BUFFER: begin
        if (data_valid_i) fsm_ns = SIB_ACTIVE;
      end
      SIB_ACTIVE: begin
        if (last_sample) fsm_ns = SIB_DONE;
      end
      SIB_DONE: begin
        fsm_ns = SIB_DONE;
      end
      default: begin
        fsm_ns = SIB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fsm_ps <= SIB_IDLE;
    end else if (zeroize_i) begin
      fsm_ps <= SIB_IDLE;
    end else begin
      fsm_ps <= fsm_ns;
    end
  end

  // Low word fills bits 0-31 and the second word the top 28 bits
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_buffer <= '0;
    end else if (zeroize_i) begin
      sign_buffer <= '0;
    end else if ((fsm_ps == SIB_IDLE) && data_valid_i) begin
      sign_buffer[SIB_NUM_SAMPLERS*SIB_SAMPLE_W-1:0] <= data_word;
    end else if ((fsm_ps == SIB_SIGN_BUFFER) && data_valid_i) begin
      sign_buffer[SIB_TAU-1:SIB_NUM_SAMPLERS*SIB_SAMPLE_W] <=
        data_word[SIB_TAU-SIB_NUM_SAMPLERS*SIB_SAMPLE_W-1:0];
    end else if (accept) begin
      sign_buffer <= sign_buffer >> 1;
    end
  end

  // Starts at 256 - TAU and steps once per accepted sample
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rej_value <= SIB_SAMPLE_W'(SIB_NUM_COEFF - SIB_TAU);
    end else if (zeroize_i) begin
      rej_value <= SIB_SAMPLE_W'(SIB_NUM_COEFF - SIB_TAU);
    end else if (accept) begin
      rej_value <= rej_value + 1'b1;
    end
  end

  // Reopen all bytes whenever a fresh word arrives
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sample_mask <= '1;
    end else if (zeroize_i || (fsm_ps != SIB_ACTIVE)) begin
      sample_mask <= '1;
    end else if (active && !data_hold_o) begin
      sample_mask <= '1;
    end else if (accept) begin
      sample_mask <= sample_mask_d;
    end
  end

  // All sign bits used up and the counter wrapped past 255
  a_done_consumed: assert property (@(posedge clk) disable iff (!rst_b)
    (fsm_ps == SIB_DONE) |-> ((sign_buffer == '0) && (rej_value == '0)));

endmodule

//--- rtl/sib_poly_mem.sv
//############################
// Challenge polynomial memory
// Two swap ports plus a host read port
//############################

module sib_poly_mem (
  input  logic                                clk,
  input  logic                                rst_b,
  input  logic                                zeroize_i,
  input  logic [1:0]                          cs_i,
  input  logic [1:0]                          we_i,
  input  logic [1:0][sib_pkg::SIB_MEM_ADDR_W-1:0] addr_i,
  input  logic [1:0][sib_pkg::SIB_COEFFS_PER_WORD-1:0][sib_pkg::SIB_COEFF_W-1:0] wrdata_i,
  input  logic [$clog2(sib_pkg::SIB_NUM_COEFF)-1:0] coeff_idx_i,
  output logic [1:0][sib_pkg::SIB_COEFFS_PER_WORD-1:0][sib_pkg::SIB_COEFF_W-1:0] rddata_o,
  output logic [sib_pkg::SIB_COEFF_W-1:0]     coeff_o
);
  import sib_pkg::*;

  logic [SIB_COEFFS_PER_WORD-1:0][SIB_COEFF_W-1:0] mem [2**SIB_MEM_ADDR_W];

  logic [SIB_MEM_ADDR_W-1:0]              host_word;
  logic [$clog2(SIB_COEFFS_PER_WORD)-1:0] host_lane;

  assign {host_word, host_lane} = coeff_idx_i;

  // Zeroize wipes every word in a single cycle
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      mem <= '{default: '0};
    end else if (zeroize_i) begin
      mem <= '{default: '0};
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (cs_i[p] && we_i[p]) begin
          mem[addr_i[p]] <= wrdata_i[p];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      if (cs_i[p] && !we_i[p]) begin
        rddata_o[p] <= mem[addr_i[p]];
      end
    end
    coeff_o <= mem[host_word][host_lane];
  end

  a_no_write_collision: assert property (@(posedge clk) disable iff (!rst_b)
    !((&(cs_i & we_i)) && (addr_i[0] == addr_i[1])));

endmodule

//--- common/sib_pkg.sv
//############################
// SampleInBall shared sizes, modulus
// and state encodings
//############################

package sib_pkg;

  // Input stream shape, four bytes per word
  localparam int SIB_NUM_SAMPLERS = 4;
  localparam int SIB_SAMPLE_W     = 8;

  // Challenge polynomial
  localparam int SIB_TAU       = 60;
  localparam int SIB_NUM_COEFF = 256;

  // ML-DSA modulus and coefficient width
  localparam int MLDSA_Q     = 8380417;
  localparam int SIB_COEFF_W = 23;

  // Coefficient memory geometry
  localparam int SIB_COEFFS_PER_WORD = 4;
  localparam int SIB_MEM_ADDR_W      = 6;

  // Controller phases
  typedef enum logic [1:0] {
    SIB_IDLE,
    SIB_SIGN_BUFFER,
    SIB_ACTIVE,
    SIB_DONE
  } sib_fsm_state_e;

  // Shuffler read-modify-write phases
  typedef enum logic {
    SHUF_READ,
    SHUF_WRITE
  } sib_shuf_state_e;

endpackage
